// File: Bender.yml
package:
  name: camera_stats

sources:
  - hdl/camera_pkg.sv
  - hdl/pixel_counter.sv
  - hdl/window_crop.sv
  - hdl/exposure_meter.sv
  - hdl/camera_regs.sv
  - hdl/camera_top.sv
  - target: simulation
    files:
      - dv/camera_asserts.sv
      - dv/camera_tb.sv

// File: dv/camera_asserts.sv
`timescale 1ns/1ns
`default_nettype none

module camera_asserts (
    input logic mipi_byte_clock,
    input logic mipi_byte_reset_n,
    input logic psel_i,
    input logic penable_i,
    input logic meter_done_i,
    input logic cfg_enable_i,
    input logic pixel_valid_i
);

    done_pulse_a: assert property (
        @(posedge mipi_byte_clock) disable iff (!mipi_byte_reset_n)
        meter_done_i |=> !meter_done_i
    ) else $error("meter_done stayed high for more than one cycle");

    // Enable only changes between frames, so a beat never meets a cleared enable
    crop_enable_a: assert property (
        @(posedge mipi_byte_clock) disable iff (!mipi_byte_reset_n)
        pixel_valid_i |-> cfg_enable_i
    ) else $error("pixel_valid_o high while the crop was disabled");

    apb_setup_a: assert property (
        @(posedge mipi_byte_clock) disable iff (!mipi_byte_reset_n)
        $rose(penable_i) |-> psel_i && $past(psel_i && !penable_i)
    ) else $error("penable rose without a preceding APB setup cycle");

endmodule

bind camera_top camera_asserts asserts_i (
    .mipi_byte_clock   (mipi_byte_clock),
    .mipi_byte_reset_n (mipi_byte_reset_n),
    .psel_i            (psel_i),
    .penable_i         (penable_i),
    .meter_done_i      (meter_done),
    .cfg_enable_i      (cfg_enable),
    .pixel_valid_i     (pixel_valid_o)
);

`default_nettype wire

// File: dv/camera_tb.sv
`timescale 1ns/1ns
`default_nettype none

module camera_tb
    import camera_pkg::*;
();

    typedef struct {
        int        width;
        int        height;
        int        x_start;
        int        y_start;
        win_size_e size;
        bit        enable;
    } frame_row_t;

    localparam int NUM_ROWS = 6;

    frame_row_t frame_table [NUM_ROWS] = '{
        '{40, 24,  4,  3, WIN_16, 1'b1},
        '{48, 40,  8,  4, WIN_32, 1'b1},
        '{80, 70, 10,  2, WIN_64, 1'b1},
        '{40, 30, 30, 20, WIN_16, 1'b1},   // Window hangs off the corner
        '{32, 20,  0,  0, WIN_16, 1'b0},   // Crop disabled
        '{36, 36,  2,  2, WIN_32, 1'b1}
    };

    logic                  mipi_byte_clock = 1'b0;
    logic                  mipi_byte_reset_n = 1'b0;
    logic [PIXEL_W-1:0]    payload = '0;
    logic                  payload_valid = 1'b0;
    logic                  line_valid = 1'b0;
    logic                  frame_valid = 1'b0;
    logic                  psel = 1'b0;
    logic                  penable = 1'b0;
    logic                  pwrite = 1'b0;
    logic [APB_ADDR_W-1:0] paddr = '0;
    logic [APB_DATA_W-1:0] pwdata = '0;
    logic [APB_DATA_W-1:0] prdata;
    logic [PIXEL_W-1:0]    pixel;
    logic                  pixel_valid;
    logic [PIXEL_W-1:0]    frame_mem [0:8191];
    int                    beat_cnt = 0;
    int                    beat_sum = 0;
    int                    checks = 0;
    int                    errors = 0;
    int                    frames_sent = 0;

    camera_top dut_i (
        .mipi_byte_clock   (mipi_byte_clock),
        .mipi_byte_reset_n (mipi_byte_reset_n),
        .payload_i         (payload),
        .payload_valid_i   (payload_valid),
        .line_valid_i      (line_valid),
        .frame_valid_i     (frame_valid),
        .psel_i            (psel),
        .penable_i         (penable),
        .pwrite_i          (pwrite),
        .paddr_i           (paddr),
        .pwdata_i          (pwdata),
        .prdata_o          (prdata),
        .pixel_o           (pixel),
        .pixel_valid_o     (pixel_valid)
    );

    always #20 mipi_byte_clock = ~mipi_byte_clock;

    always @(negedge mipi_byte_clock) begin
        if (pixel_valid) begin             // Outputs settle after the rising edge
            beat_cnt++;
            beat_sum += pixel;
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("FAIL %s got 0x%0h expected 0x%0h", name, got, exp);
            errors++;
        end
    endtask

    task automatic apb_write(input logic [APB_ADDR_W-1:0] addr, input logic [31:0] data);
        @(negedge mipi_byte_clock);
        psel = 1'b1;
        pwrite = 1'b1;
        paddr = addr;
        pwdata = data;
        @(negedge mipi_byte_clock);
        penable = 1'b1;
        @(negedge mipi_byte_clock);
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
    endtask

    task automatic apb_read(input logic [APB_ADDR_W-1:0] addr, output logic [31:0] data);
        @(negedge mipi_byte_clock);
        psel = 1'b1;
        pwrite = 1'b0;
        paddr = addr;
        @(negedge mipi_byte_clock);
        penable = 1'b1;
        @(negedge mipi_byte_clock);
        data = prdata;                     // Held since the setup phase
        psel = 1'b0;
        penable = 1'b0;
    endtask

    task automatic stream_frame(input int width, input int height);
        @(negedge mipi_byte_clock);
        frame_valid = 1'b1;
        for (int y = 0; y < height; y++) begin
            for (int x = 0; x < width; x++) begin
                @(negedge mipi_byte_clock);
                line_valid = 1'b1;
                payload_valid = 1'b1;
                payload = PIXEL_W'($urandom);
                frame_mem[y * width + x] = payload;
            end
            @(negedge mipi_byte_clock);
            line_valid = 1'b0;
            payload_valid = 1'b0;
            @(negedge mipi_byte_clock);    // Second idle cycle
        end
        frame_valid = 1'b0;
        frames_sent++;
    endtask

    // Half-open square window, counted only when the crop is enabled
    task automatic model_frame(input frame_row_t row, output int exp_cnt, output int exp_sum);
        int side;
        side = 16 << int'(row.size);
        exp_cnt = 0;
        exp_sum = 0;
        for (int y = 0; y < row.height; y++) begin
            for (int x = 0; x < row.width; x++) begin
                if (row.enable && x >= row.x_start && x < row.x_start + side &&
                    y >= row.y_start && y < row.y_start + side) begin
                    exp_cnt++;
                    exp_sum += frame_mem[y * row.width + x];
                end
            end
        end
    endtask

    task automatic wait_ready(output bit seen);
        logic [31:0] rd;
        seen = 1'b0;
        for (int i = 0; i < 40 && !seen; i++) begin   // Poll with a bound
            apb_read(REG_STATUS, rd);
            seen = rd[STATUS_READY_BIT];
        end
    endtask

    initial begin
        logic [31:0] rd;
        frame_row_t  row;
        int          exp_cnt;
        int          exp_sum;
        int          shift;
        int          err_before;
        bit          seen;
        void'($urandom(17));
        repeat (3) @(negedge mipi_byte_clock);
        mipi_byte_reset_n = 1'b1;
        apb_read(REG_STATUS, rd);
        check_value("REG_STATUS", rd, 32'h0);
        apb_read(8'h18, rd);
        check_value("prdata_o unmapped", rd, 32'h0);
        for (int t = 0; t < NUM_ROWS; t++) begin
            row = frame_table[t];
            err_before = errors;
            apb_write(REG_CTRL, (int'(row.size) << CTRL_SIZE_LSB) | int'(row.enable));
            apb_write(REG_X_START, row.x_start);
            apb_write(REG_Y_START, row.y_start);
            apb_read(REG_CTRL, rd);
            check_value("REG_CTRL", rd, (int'(row.size) << CTRL_SIZE_LSB) | int'(row.enable));
            apb_read(REG_X_START, rd);
            check_value("REG_X_START", rd, row.x_start);
            apb_read(REG_Y_START, rd);
            check_value("REG_Y_START", rd, row.y_start);
            beat_cnt = 0;
            beat_sum = 0;
            stream_frame(row.width, row.height);
            model_frame(row, exp_cnt, exp_sum);
            wait_ready(seen);
            checks++;
            assert (seen) else begin
                $display("Meter ready flag never set after frame %0d", t);
                errors++;
            end
            shift = 8 + 2 * int'(row.size);
            check_value("pixel_o beats", beat_cnt, exp_cnt);
            check_value("pixel_o sum", beat_sum, exp_sum);
            apb_read(REG_METER, rd);
            check_value("REG_METER", rd, (exp_sum >> shift) & 8'hFF);
            apb_write(REG_STATUS, 32'h1);  // Clear the ready flag
            apb_read(REG_STATUS, rd);
            check_value("REG_STATUS after clear", rd, 32'h0);
            $display("Test %0d: %0dx%0d frame, size code %0d, enable %0d, %0d beats: %s",
                     t, row.width, row.height, row.size, row.enable, beat_cnt,
                     (errors == err_before) ? "ok" : "errors");
        end
        apb_read(REG_FRAMES, rd);
        check_value("REG_FRAMES", rd, frames_sent);
        $display("Tests %0d, checks %0d, errors %0d", NUM_ROWS, checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: hdl/camera_pkg.sv
`default_nettype none

package camera_pkg;

    localparam int PIXEL_W     = 8;    // RAW8 from the CSI-2 receiver
    localparam int COORD_W     = 11;   // Frames up to 2047 x 2047
    localparam int ACC_W       = 20;   // 64 x 64 pixels at 255 fits
    localparam int FRAME_CNT_W = 16;
    localparam int APB_ADDR_W  = 8;
    localparam int APB_DATA_W  = 32;

    // Window size code rules, decoded locally by each stage:
    // side length is WIN_SIDE_BASE << code, giving 16, 32 or 64 pixels
    // meter shift is METER_SHIFT_BASE + 2 * code, giving 8, 10 or 12
    localparam int WIN_SIZE_W       = 2;
    localparam int WIN_SIDE_BASE    = 16;
    localparam int METER_SHIFT_BASE = 8;

    typedef enum logic [WIN_SIZE_W-1:0] {
        WIN_16 = 2'd0,
        WIN_32 = 2'd1,
        WIN_64 = 2'd2
    } win_size_e;

    typedef enum logic [APB_ADDR_W-1:0] {
        REG_CTRL    = 8'h00,   // Enable and size code
        REG_X_START = 8'h04,
        REG_Y_START = 8'h08,
        REG_STATUS  = 8'h0C,   // Meter ready, write 1 to clear
        REG_METER   = 8'h10,   // Window average
        REG_FRAMES  = 8'h14    // Completed frames
    } reg_addr_e;

    // Bit positions inside REG_CTRL and REG_STATUS
    localparam int CTRL_ENABLE_BIT  = 0;
    localparam int CTRL_SIZE_LSB    = 1;
    localparam int STATUS_READY_BIT = 0;

endpackage

`default_nettype wire

// File: hdl/camera_regs.sv
`timescale 1ns/1ns
`default_nettype none

module camera_regs
    import camera_pkg::*;
(
    input  logic                  mipi_byte_clock,
    input  logic                  mipi_byte_reset_n,
    input  logic                  psel_i,
    input  logic                  penable_i,
    input  logic                  pwrite_i,
    input  logic [APB_ADDR_W-1:0] paddr_i,
    input  logic [APB_DATA_W-1:0] pwdata_i,
    input  logic [PIXEL_W-1:0]    meter_avg_i,
    input  logic                  meter_done_i,
    output logic [APB_DATA_W-1:0] prdata_o,
    output logic                  cfg_enable_o,
    output win_size_e             cfg_size_o,
    output logic [COORD_W-1:0]    cfg_x_start_o,
    output logic [COORD_W-1:0]    cfg_y_start_o
);

    reg_addr_e              addr;
    logic                   apb_write;
    logic                   apb_setup_read;
    logic                   ready_clear;
    logic                   ready_q;
    logic [PIXEL_W-1:0]     avg_q;
    logic [FRAME_CNT_W-1:0] frames_q;
    logic [APB_DATA_W-1:0]  rdata;

    always_comb begin
        addr           = reg_addr_e'(paddr_i);
        apb_write      = psel_i & penable_i & pwrite_i;      // Access phase
        apb_setup_read = psel_i & ~penable_i & ~pwrite_i;    // Setup phase
        ready_clear    = apb_write && (addr == REG_STATUS) && pwdata_i[STATUS_READY_BIT];
    end

    always_ff @(posedge mipi_byte_clock or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            cfg_enable_o  <= 1'b0;
            cfg_size_o    <= WIN_16;
            cfg_x_start_o <= '0;
            cfg_y_start_o <= '0;
        end else if (apb_write) begin
            case (addr)
                REG_CTRL: begin
                    cfg_enable_o <= pwdata_i[CTRL_ENABLE_BIT];
                    cfg_size_o   <= win_size_e'(pwdata_i[CTRL_SIZE_LSB +: WIN_SIZE_W]);
                end
                REG_X_START: cfg_x_start_o <= pwdata_i[COORD_W-1:0];
                REG_Y_START: cfg_y_start_o <= pwdata_i[COORD_W-1:0];
                default: ;
            endcase
        end
    end

    // Meter results and frame count
    always_ff @(posedge mipi_byte_clock or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            ready_q  <= 1'b0;
            avg_q    <= '0;
            frames_q <= '0;
        end else begin
            if (meter_done_i) begin
                ready_q  <= 1'b1;          // Set wins over a clear
                avg_q    <= meter_avg_i;
                frames_q <= frames_q + 1'b1;
            end else if (ready_clear) begin
                ready_q  <= 1'b0;
            end
        end
    end

    always_comb begin
        rdata = '0;                        // Unmapped reads as zero
        case (addr)
            REG_CTRL: begin
                rdata[CTRL_ENABLE_BIT]             = cfg_enable_o;
                rdata[CTRL_SIZE_LSB +: WIN_SIZE_W] = cfg_size_o;
            end
            REG_X_START: rdata[COORD_W-1:0]     = cfg_x_start_o;
            REG_Y_START: rdata[COORD_W-1:0]     = cfg_y_start_o;
            REG_STATUS:  rdata[STATUS_READY_BIT] = ready_q;
            REG_METER:   rdata[PIXEL_W-1:0]     = avg_q;
            REG_FRAMES:  rdata[FRAME_CNT_W-1:0] = frames_q;
            default: ;
        endcase
    end

    always_ff @(posedge mipi_byte_clock or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            prdata_o <= '0;
        end else if (apb_setup_read) begin
            prdata_o <= rdata;             // Stable through the access phase
        end
    end

endmodule

`default_nettype wire

// File: hdl/camera_top.sv
`timescale 1ns/1ns
`default_nettype none

module camera_top
    import camera_pkg::*;
(
    input  logic                  mipi_byte_clock,
    input  logic                  mipi_byte_reset_n,
    input  logic [PIXEL_W-1:0]    payload_i,
    input  logic                  payload_valid_i,
    input  logic                  line_valid_i,
    input  logic                  frame_valid_i,
    input  logic                  psel_i,
    input  logic                  penable_i,
    input  logic                  pwrite_i,
    input  logic [APB_ADDR_W-1:0] paddr_i,
    input  logic [APB_DATA_W-1:0] pwdata_i,
    output logic [APB_DATA_W-1:0] prdata_o,
    output logic [PIXEL_W-1:0]    pixel_o,
    output logic                  pixel_valid_o
);

    logic [PIXEL_W-1:0] pix_data;
    logic               pix_valid;
    logic [COORD_W-1:0] pix_x;
    logic [COORD_W-1:0] pix_y;
    logic               frame_start;
    logic               frame_end;
    logic [PIXEL_W-1:0] crop_data;
    logic               crop_valid;
    logic               crop_frame_start;
    logic               crop_frame_end;
    logic [PIXEL_W-1:0] meter_avg;
    logic               meter_done;
    logic               cfg_enable;
    win_size_e          cfg_size;
    logic [COORD_W-1:0] cfg_x_start;
    logic [COORD_W-1:0] cfg_y_start;

    assign pixel_o       = crop_data;      // Cropped stream leaves the block
    assign pixel_valid_o = crop_valid;

    pixel_counter pixel_counter_i (
        .mipi_byte_clock   (mipi_byte_clock),
        .mipi_byte_reset_n (mipi_byte_reset_n),
        .payload_i         (payload_i),
        .payload_valid_i   (payload_valid_i),
        .line_valid_i      (line_valid_i),
        .frame_valid_i     (frame_valid_i),
        .pix_data_o        (pix_data),
        .pix_valid_o       (pix_valid),
        .pix_x_o           (pix_x),
        .pix_y_o           (pix_y),
        .frame_start_o     (frame_start),
        .frame_end_o       (frame_end)
    );

    window_crop window_crop_i (
        .mipi_byte_clock    (mipi_byte_clock),
        .mipi_byte_reset_n  (mipi_byte_reset_n),
        .pix_data_i         (pix_data),
        .pix_valid_i        (pix_valid),
        .pix_x_i            (pix_x),
        .pix_y_i            (pix_y),
        .frame_start_i      (frame_start),
        .frame_end_i        (frame_end),
        .cfg_enable_i       (cfg_enable),
        .cfg_size_i         (cfg_size),
        .cfg_x_start_i      (cfg_x_start),
        .cfg_y_start_i      (cfg_y_start),
        .crop_data_o        (crop_data),
        .crop_valid_o       (crop_valid),
        .crop_frame_start_o (crop_frame_start),
        .crop_frame_end_o   (crop_frame_end)
    );

    exposure_meter exposure_meter_i (
        .mipi_byte_clock    (mipi_byte_clock),
        .mipi_byte_reset_n  (mipi_byte_reset_n),
        .crop_data_i        (crop_data),
        .crop_valid_i       (crop_valid),
        .crop_frame_start_i (crop_frame_start),
        .crop_frame_end_i   (crop_frame_end),
        .cfg_size_i         (cfg_size),
        .meter_avg_o        (meter_avg),
        .meter_done_o       (meter_done)
    );

    camera_regs camera_regs_i (
        .mipi_byte_clock   (mipi_byte_clock),
        .mipi_byte_reset_n (mipi_byte_reset_n),
        .psel_i            (psel_i),
        .penable_i         (penable_i),
        .pwrite_i          (pwrite_i),
        .paddr_i           (paddr_i),
        .pwdata_i          (pwdata_i),
        .meter_avg_i       (meter_avg),
        .meter_done_i      (meter_done),
        .prdata_o          (prdata_o),
        .cfg_enable_o      (cfg_enable),
        .cfg_size_o        (cfg_size),
        .cfg_x_start_o     (cfg_x_start),
        .cfg_y_start_o     (cfg_y_start)
    );

endmodule

`default_nettype wire

// File: hdl/exposure_meter.sv
`timescale 1ns/1ns
`default_nettype none

module exposure_meter
    import camera_pkg::*;
(
    input  logic               mipi_byte_clock,
    input  logic               mipi_byte_reset_n,
    input  logic [PIXEL_W-1:0] crop_data_i,
    input  logic               crop_valid_i,
    input  logic               crop_frame_start_i,
    input  logic               crop_frame_end_i,
    input  win_size_e          cfg_size_i,
    output logic [PIXEL_W-1:0] meter_avg_o,
    output logic               meter_done_o
);

    localparam int SHIFT_W = 4;

    logic [ACC_W-1:0]   acc;
    logic [ACC_W-1:0]   acc_next;
    logic [SHIFT_W-1:0] shift;

    // Divide by the full window area even when the window leaves the frame
    always_comb begin
        case (cfg_size_i)
            WIN_32:  shift = SHIFT_W'(METER_SHIFT_BASE + 2);
            WIN_64:  shift = SHIFT_W'(METER_SHIFT_BASE + 4);
            default: shift = SHIFT_W'(METER_SHIFT_BASE);
        endcase
    end

    always_comb begin
        acc_next = crop_frame_start_i ? '0 : acc;    // New frame restarts the sum
        if (crop_valid_i) begin
            acc_next = acc_next + ACC_W'(crop_data_i);
        end
    end

    always_ff @(posedge mipi_byte_clock or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            acc          <= '0;
            meter_avg_o  <= '0;
            meter_done_o <= 1'b0;
        end else begin
            acc          <= acc_next;
            meter_done_o <= crop_frame_end_i;
            if (crop_frame_end_i) begin
                meter_avg_o <= PIXEL_W'(acc_next >> shift);   // Truncated
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/pixel_counter.sv
`timescale 1ns/1ns
`default_nettype none

module pixel_counter
    import camera_pkg::*;
(
    input  logic               mipi_byte_clock,
    input  logic               mipi_byte_reset_n,
    input  logic [PIXEL_W-1:0] payload_i,
    input  logic               payload_valid_i,
    input  logic               line_valid_i,
    input  logic               frame_valid_i,
    output logic [PIXEL_W-1:0] pix_data_o,
    output logic               pix_valid_o,
    output logic [COORD_W-1:0] pix_x_o,
    output logic [COORD_W-1:0] pix_y_o,
    output logic               frame_start_o,
    output logic               frame_end_o
);

    logic               line_valid_q;
    logic               frame_valid_q;
    logic               line_rise;
    logic               line_fall;
    logic               frame_rise;
    logic               frame_fall;
    logic               pixel_hit;
    logic [COORD_W-1:0] x_cnt;      // Column of the next pixel
    logic [COORD_W-1:0] y_cnt;      // Current line
    logic [COORD_W-1:0] x_cur;
    logic [COORD_W-1:0] y_cur;

    always_comb begin
        line_rise  = line_valid_i & ~line_valid_q;
        line_fall  = ~line_valid_i & line_valid_q;
        frame_rise = frame_valid_i & ~frame_valid_q;
        frame_fall = ~frame_valid_i & frame_valid_q;
        pixel_hit  = payload_valid_i & line_valid_i;   // Both enables needed
        x_cur      = line_rise ? '0 : x_cnt;
        y_cur      = frame_rise ? '0 : y_cnt;
    end

    always_ff @(posedge mipi_byte_clock or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            line_valid_q  <= 1'b0;
            frame_valid_q <= 1'b0;
            pix_valid_o   <= 1'b0;
            frame_start_o <= 1'b0;
            frame_end_o   <= 1'b0;
            x_cnt         <= '0;
            y_cnt         <= '0;
            pix_x_o       <= '0;
            pix_y_o       <= '0;
        end else begin
            line_valid_q  <= line_valid_i;
            frame_valid_q <= frame_valid_i;
            pix_valid_o   <= pixel_hit;
            frame_start_o <= frame_rise;
            frame_end_o   <= frame_fall;
            pix_x_o       <= x_cur;
            pix_y_o       <= y_cur;
            x_cnt         <= pixel_hit ? x_cur + 1'b1 : x_cur;
            if (frame_rise) begin
                y_cnt <= '0;
            end else if (line_fall) begin
                y_cnt <= y_cnt + 1'b1;     // Next line
            end
        end
    end

    always_ff @(posedge mipi_byte_clock) begin
        pix_data_o <= payload_i;
    end

endmodule

`default_nettype wire

// File: hdl/window_crop.sv
`timescale 1ns/1ns
`default_nettype none

module window_crop
    import camera_pkg::*;
(
    input  logic               mipi_byte_clock,
    input  logic               mipi_byte_reset_n,
    input  logic [PIXEL_W-1:0] pix_data_i,
    input  logic               pix_valid_i,
    input  logic [COORD_W-1:0] pix_x_i,
    input  logic [COORD_W-1:0] pix_y_i,
    input  logic               frame_start_i,
    input  logic               frame_end_i,
    input  logic               cfg_enable_i,
    input  win_size_e          cfg_size_i,
    input  logic [COORD_W-1:0] cfg_x_start_i,
    input  logic [COORD_W-1:0] cfg_y_start_i,
    output logic [PIXEL_W-1:0] crop_data_o,
    output logic               crop_valid_o,
    output logic               crop_frame_start_o,
    output logic               crop_frame_end_o
);

    localparam int END_W = COORD_W + 1;   // Window end may pass 2047

    logic [END_W-1:0] side;
    logic [END_W-1:0] x_end;
    logic [END_W-1:0] y_end;
    logic             in_window;

    always_comb begin
        case (cfg_size_i)
            WIN_32:  side = END_W'(WIN_SIDE_BASE << 1);
            WIN_64:  side = END_W'(WIN_SIDE_BASE << 2);
            default: side = END_W'(WIN_SIDE_BASE);
        endcase
        x_end     = {1'b0, cfg_x_start_i} + side;
        y_end     = {1'b0, cfg_y_start_i} + side;
        // Half-open on both axes
        in_window = (pix_x_i >= cfg_x_start_i) && ({1'b0, pix_x_i} < x_end) &&
                    (pix_y_i >= cfg_y_start_i) && ({1'b0, pix_y_i} < y_end);
    end

    always_ff @(posedge mipi_byte_clock or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            crop_valid_o       <= 1'b0;
            crop_frame_start_o <= 1'b0;
            crop_frame_end_o   <= 1'b0;
        end else begin
            crop_valid_o       <= pix_valid_i & cfg_enable_i & in_window;
            crop_frame_start_o <= frame_start_i;   // Kept aligned with the data
            crop_frame_end_o   <= frame_end_i;
        end
    end

    always_ff @(posedge mipi_byte_clock) begin
        crop_data_o <= pix_data_i;
    end

endmodule

`default_nettype wire

// File: sources.f
hdl/camera_pkg.sv
hdl/pixel_counter.sv
hdl/window_crop.sv
hdl/exposure_meter.sv
hdl/camera_regs.sv
hdl/camera_top.sv
dv/camera_asserts.sv
dv/camera_tb.sv
